//--- dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    op_e              op;
    logic [ARN_W-1:0] arn;
    logic [XLEN-1:0]  data;
    logic             bad;  // branch prediction differs from resolution
} model_inst_t;

model_inst_t     prog_q [$];  // accepted and not yet retired, oldest first
logic [XLEN-1:0] shadow [8];  // architectural register shadow
int              accepted_cnt;
int              retired_cnt;

function automatic logic [XLEN-1:0] expected_result(input op_e op, input logic [XLEN-1:0] operand);
    case (op)
        op_alu:  return operand + 16'd1;
        op_mul:  return XLEN'(32'(operand) * 3);
        default: return '0;  // branches yield no data
    endcase
endfunction

// resolved direction is operand bit 0, resolved target is operand >> 1
function automatic logic mispredicted(input op_e op, input logic [XLEN-1:0] operand,
                                      input logic pred_taken, input logic [XLEN-1:0] pred_target);
    if (op != op_branch) begin
        return 1'b0;
    end
    return (pred_taken != operand[0]) || (pred_target != (operand >> 1));
endfunction

task automatic model_accept(input op_e op, input logic [ARN_W-1:0] arn,
                            input logic [XLEN-1:0] operand, input logic pred_taken,
                            input logic [XLEN-1:0] pred_target);
    model_inst_t m;
    m.op   = op;
    m.arn  = arn;
    m.data = expected_result(op, operand);
    m.bad  = mispredicted(op, operand, pred_taken, pred_target);
    prog_q.push_back(m);
    accepted_cnt++;
endtask

task automatic model_retire(input model_inst_t m);
    if (m.op != op_branch) begin
        shadow[m.arn] = m.data;
    end
    retired_cnt++;
endtask

`endif

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import rob_pkg::*;
();

    localparam int WIDTH      = 2;
    localparam int ROB_SIZE   = 16;
    localparam int WAIT_LIMIT = ROB_SIZE * (LAT_MUL + 2) * 4;  // cycles before a wait gives up

    logic                        clock = 1'b0;
    logic                        reset;
    logic [WIDTH-1:0]            in_valid;
    op_e  [WIDTH-1:0]            in_op;
    logic [WIDTH-1:0][ARN_W-1:0] in_arn;
    logic [WIDTH-1:0][XLEN-1:0]  in_operand;
    logic [WIDTH-1:0]            in_pred_taken;
    logic [WIDTH-1:0][XLEN-1:0]  in_pred_target;
    logic [ARN_W-1:0]            arch_rd_arn;
    logic                        ready;
    logic [WIDTH-1:0]            commit_valid;
    logic [WIDTH-1:0][ARN_W-1:0] commit_arn;
    logic [WIDTH-1:0][XLEN-1:0]  commit_data;
    logic                        squash;
    logic [XLEN-1:0]             arch_rd_data;
    logic [STAT_W-1:0]           retired_count;
    logic [STAT_W-1:0]           dispatched_count;

    logic [15:0] lfsr;
    logic        rdy_at_edge;
    logic        saw_stall;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          squash_cnt;
    string       cur_test;

    `include "tb_model.svh"

    ooo_core_top #(.WIDTH(WIDTH), .ROB_SIZE(ROB_SIZE)) i_dut (
        .clock, .reset,
        .in_valid, .in_op, .in_arn, .in_operand, .in_pred_taken, .in_pred_target,
        .arch_rd_arn, .ready, .commit_valid, .commit_arn, .commit_data, .squash,
        .arch_rd_data, .retired_count, .dispatched_count
    );

    always #10 clock = ~clock;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic compare_val(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s: expected %0h, actual %0h", cur_test, name, expected, actual);
            errors++;
        end
    endtask

    task automatic retire_check(input int lane);
        model_inst_t m;
        if (prog_q.size() == 0) begin
            $display("%s: commit on lane %0d with nothing outstanding", cur_test, lane);
            errors++;
        end else begin
            m = prog_q.pop_front();
            compare_val("commit arn", 32'(m.arn), 32'(commit_arn[lane]));
            compare_val("commit data", 32'(m.data), 32'(commit_data[lane]));
            compare_val("mispredicted branch retired", 32'd0, 32'(m.bad));
            model_retire(m);
        end
    endtask

    // commits first, then a squash drops the rest of the queue
    task automatic watch_commits();
        for (int i = 0; i < WIDTH; i++) begin
            if (commit_valid[i]) begin
                retire_check(i);
            end
        end
        if (squash) begin
            squash_cnt++;
            if (prog_q.size() == 0) begin
                $display("%s: squash with nothing outstanding", cur_test);
                errors++;
            end else begin
                compare_val("squash head is branch", 32'd1, 32'(prog_q[0].op == op_branch));
                compare_val("squash head mispredicted", 32'd1, 32'(prog_q[0].bad));
                prog_q.delete();
            end
        end
    endtask

    // outputs sampled at the falling edge where they are settled
    task automatic step();
        @(negedge clock);
        rdy_at_edge = ready;
        watch_commits();
        @(posedge clock);
    endtask

    task automatic send_group(input logic burst, input op_e burst_op, input logic allow_bad);
        int         lanes;
        int         waited;
        logic [2:0] kind;
        lanes = burst ? WIDTH : 1 + int'(rand_bits(1));
        for (int i = 0; i < WIDTH; i++) begin
            kind = 3'(rand_bits(3));
            if (burst) begin
                in_op[i] = burst_op;
            end else if (kind < 3'd4) begin
                in_op[i] = op_alu;
            end else if (kind < 3'd6) begin
                in_op[i] = op_mul;
            end else begin
                in_op[i] = op_branch;
            end
            in_arn[i]         = ARN_W'(rand_bits(ARN_W));
            in_operand[i]     = XLEN'(rand_bits(XLEN));
            in_pred_taken[i]  = in_operand[i][0];
            in_pred_target[i] = in_operand[i] >> 1;
            if (allow_bad && rand_bits(2) == 32'd0) begin
                if (rand_bits(1) == 32'd1) begin
                    in_pred_taken[i] = ~in_pred_taken[i];
                end else begin
                    in_pred_target[i] = in_pred_target[i] ^ XLEN'(1);
                end
            end
            in_valid[i] = (i < lanes);  // packed from lane 0
        end
        waited      = 0;
        rdy_at_edge = 1'b0;
        while (!rdy_at_edge && waited < WAIT_LIMIT) begin
            step();
            if (!rdy_at_edge) begin
                saw_stall = 1'b1;
            end
            waited++;
        end
        if (rdy_at_edge) begin
            for (int i = 0; i < lanes; i++) begin
                model_accept(in_op[i], in_arn[i], in_operand[i], in_pred_taken[i],
                             in_pred_target[i]);
            end
        end else begin
            $display("%s: timeout, instructions never accepted", cur_test);
            errors++;
        end
        #1;
        in_valid = '0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (prog_q.size() != 0 && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (prog_q.size() != 0) begin
            $display("%s: timeout, ROB did not drain", cur_test);
            errors++;
        end
        step();  // retire writes land at this edge
        #1;
    endtask

    // one register per cycle, read port sampled at the falling edge
    task automatic check_regs();
        for (int r = 0; r < 8; r++) begin
            arch_rd_arn = ARN_W'(r);
            @(negedge clock);
            compare_val($sformatf("r%0d", r), 32'(shadow[r]), 32'(arch_rd_data));
            @(posedge clock);
            #1;
        end
    endtask

    task automatic finish_test(input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed", cur_test);
        end
    endtask

    initial begin
        int e;
        int sq_before;
        reset          = 1'b1;
        in_valid       = '0;
        in_arn         = '0;
        in_operand     = '0;
        in_pred_taken  = '0;
        in_pred_target = '0;
        arch_rd_arn    = '0;
        for (int i = 0; i < WIDTH; i++) begin
            in_op[i] = op_alu;
        end
        for (int r = 0; r < 8; r++) begin
            shadow[r] = '0;
        end
        lfsr         = 16'd80;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        squash_cnt   = 0;
        accepted_cnt = 0;
        retired_cnt  = 0;
        saw_stall    = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        cur_test = "reset_state";
        e = errors;
        compare_val("ready", 32'd1, 32'(ready));
        compare_val("commit_valid", 32'd0, 32'(commit_valid));
        compare_val("squash", 32'd0, 32'(squash));
        compare_val("retired_count", 32'd0, 32'(retired_count));
        check_regs();
        finish_test(e);

        cur_test = "in_order_commit";
        e = errors;
        repeat (40) send_group(1'b0, op_alu, 1'b0);
        drain();
        finish_test(e);

        // a mul pair near the top slots starves behind wrapped alu pairs
        cur_test = "back_pressure";
        e = errors;
        saw_stall = 1'b0;
        for (int g = 0; g < 56; g++) begin
            send_group(1'b1, (g % 7 == 0) ? op_mul : op_alu, 1'b0);
        end
        drain();
        compare_val("ready fell", 32'd1, 32'(saw_stall));
        compare_val("retired_count", 32'(accepted_cnt), retired_count);
        compare_val("dispatched_count", 32'(accepted_cnt), dispatched_count);
        finish_test(e);

        cur_test = "mispredict_squash";
        e = errors;
        sq_before = squash_cnt;
        repeat (60) send_group(1'b0, op_alu, 1'b1);
        drain();
        compare_val("squash seen", 32'd1, 32'(squash_cnt > sq_before));
        finish_test(e);

        cur_test = "arch_state";
        e = errors;
        repeat (200) send_group(1'b0, op_alu, 1'b1);
        drain();
        check_regs();
        compare_val("retired_count", 32'(retired_cnt), retired_count);
        compare_val("dispatched_count", 32'(accepted_cnt), dispatched_count);
        finish_test(e);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- logic/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit
    import rob_pkg::*;
#(
    parameter int WIDTH  = 2,
    parameter int ROBN_W = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [WIDTH-1:0]              in_valid,
    input  op_e  [WIDTH-1:0]              in_op,
    input  logic [WIDTH-1:0][ARN_W-1:0]   in_arn,
    input  logic [WIDTH-1:0][XLEN-1:0]    in_operand,
    input  logic [WIDTH-1:0]              in_pred_taken,
    input  logic [WIDTH-1:0][XLEN-1:0]    in_pred_target,
    input  logic [WIDTH-1:0][ROBN_W-1:0]  tail_robn,
    input  logic                          almost_full,
    input  logic                          squash,
    output logic                          ready,
    output logic [WIDTH-1:0]              alloc_valid,
    output logic [WIDTH-1:0][ROBN_W-1:0]  alloc_robn,
    output op_e  [WIDTH-1:0]              alloc_op,
    output logic [WIDTH-1:0][ARN_W-1:0]   alloc_arn,
    output logic [WIDTH-1:0]              alloc_pred_taken,
    output logic [WIDTH-1:0][XLEN-1:0]    alloc_pred_target,
    output logic [WIDTH-1:0][XLEN-1:0]    issue_operand,
    output logic [STAT_W-1:0]             dispatched_count
);

    logic [STAT_W-1:0] n_accept;

    // registered ROB state only, so stable for the whole cycle
    assign ready = ~almost_full & ~squash;

    assign alloc_valid = in_valid & {WIDTH{ready}};

    // each lane takes the ROB number at tail + lane
    assign alloc_robn        = tail_robn;
    assign alloc_op          = in_op;
    assign alloc_arn         = in_arn;
    assign alloc_pred_taken  = in_pred_taken;
    assign alloc_pred_target = in_pred_target;
    assign issue_operand     = in_operand;  // operands go to exec only

    always_comb begin
        n_accept = '0;
        for (int i = 0; i < WIDTH; i++) begin
            n_accept = n_accept + STAT_W'(alloc_valid[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dispatched_count <= '0;
        end else begin
            dispatched_count <= dispatched_count + n_accept;
        end
    end

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import rob_pkg::*;
#(
    parameter int WIDTH    = 2,
    parameter int ROB_SIZE = 16,
    parameter int ROBN_W   = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [WIDTH-1:0]              alloc_valid,
    input  logic [WIDTH-1:0][ROBN_W-1:0]  alloc_robn,
    input  op_e  [WIDTH-1:0]              alloc_op,
    input  logic [WIDTH-1:0][XLEN-1:0]    issue_operand,
    input  logic                          squash,
    output logic [WIDTH-1:0]              done_valid,
    output logic [WIDTH-1:0][ROBN_W-1:0]  done_robn,
    output logic [WIDTH-1:0][XLEN-1:0]    done_data,
    output logic [WIDTH-1:0]              done_taken,
    output logic [WIDTH-1:0][XLEN-1:0]    done_target
);

    // one tracker per ROB slot
    logic [ROB_SIZE-1:0]  busy;
    logic [LAT_W-1:0]     cnt        [ROB_SIZE];
    logic [XLEN-1:0]      res_data   [ROB_SIZE];
    logic                 res_taken  [ROB_SIZE];
    logic [XLEN-1:0]      res_target [ROB_SIZE];

    logic [WIDTH-1:0][XLEN-1:0] lane_data;
    logic [WIDTH-1:0]           lane_taken;
    logic [WIDTH-1:0][XLEN-1:0] lane_target;

    logic [ROB_SIZE-1:0]          pick;
    logic [WIDTH-1:0]             sel_valid;
    logic [WIDTH-1:0][ROBN_W-1:0] sel_robn;

    // results are known at issue so only the latency is modelled
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            lane_data[i]   = '0;
            lane_taken[i]  = 1'b0;
            lane_target[i] = '0;
            case (alloc_op[i])
                op_alu:  lane_data[i] = issue_operand[i] + XLEN'(1);
                op_mul:  lane_data[i] = XLEN'(issue_operand[i] * 3);  // truncated
                default: begin
                    lane_taken[i]  = issue_operand[i][0];
                    lane_target[i] = issue_operand[i] >> 1;
                end
            endcase
        end
    end

    // up to WIDTH due slots with the lowest index first
    always_comb begin
        int n;
        n         = 0;
        pick      = '0;
        sel_valid = '0;
        sel_robn  = '0;
        for (int s = 0; s < ROB_SIZE; s++) begin
            if (busy[s] && cnt[s] == LAT_W'(1) && n < WIDTH) begin
                sel_valid[n] = 1'b1;
                sel_robn[n]  = ROBN_W'(s);
                pick[s]      = 1'b1;
                n            = n + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;  // squash kills everything in flight
        end else begin
            for (int s = 0; s < ROB_SIZE; s++) begin
                if (pick[s]) begin
                    busy[s] <= 1'b0;
                end
            end
            for (int i = 0; i < WIDTH; i++) begin
                if (alloc_valid[i]) begin
                    busy[alloc_robn[i]] <= 1'b1;
                end
            end
        end
    end

    // countdown holds at 1 while a slot waits for a lane
    always_ff @(posedge clock) begin
        for (int s = 0; s < ROB_SIZE; s++) begin
            if (busy[s] && cnt[s] > LAT_W'(1)) begin
                cnt[s] <= cnt[s] - LAT_W'(1);
            end
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (alloc_valid[i]) begin
                cnt[alloc_robn[i]]        <= op_latency(alloc_op[i]);
                res_data[alloc_robn[i]]   <= lane_data[i];
                res_taken[alloc_robn[i]]  <= lane_taken[i];
                res_target[alloc_robn[i]] <= lane_target[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            done_valid <= '0;
        end else begin
            done_valid <= sel_valid;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < WIDTH; i++) begin
            done_robn[i]   <= sel_robn[i];
            done_data[i]   <= res_data[sel_robn[i]];
            done_taken[i]  <= res_taken[sel_robn[i]];
            done_target[i] <= res_target[sel_robn[i]];
        end
    end

endmodule

//--- logic/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top
    import rob_pkg::*;
#(
    parameter int WIDTH       = 2,
    parameter int ROB_SIZE    = 16,
    parameter int ALERT_DEPTH = WIDTH
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [WIDTH-1:0]             in_valid,
    input  op_e  [WIDTH-1:0]             in_op,
    input  logic [WIDTH-1:0][ARN_W-1:0]  in_arn,
    input  logic [WIDTH-1:0][XLEN-1:0]   in_operand,
    input  logic [WIDTH-1:0]             in_pred_taken,
    input  logic [WIDTH-1:0][XLEN-1:0]   in_pred_target,
    input  logic [ARN_W-1:0]             arch_rd_arn,
    output logic                         ready,
    output logic [WIDTH-1:0]             commit_valid,
    output logic [WIDTH-1:0][ARN_W-1:0]  commit_arn,
    output logic [WIDTH-1:0][XLEN-1:0]   commit_data,
    output logic                         squash,
    output logic [XLEN-1:0]              arch_rd_data,
    output logic [STAT_W-1:0]            retired_count,
    output logic [STAT_W-1:0]            dispatched_count
);

    localparam int ROBN_W = $clog2(ROB_SIZE);

    logic [WIDTH-1:0][ROBN_W-1:0] tail_robn;
    logic                         almost_full;
    logic [WIDTH-1:0]             alloc_valid;
    logic [WIDTH-1:0][ROBN_W-1:0] alloc_robn;
    op_e  [WIDTH-1:0]             alloc_op;
    logic [WIDTH-1:0][ARN_W-1:0]  alloc_arn;
    logic [WIDTH-1:0]             alloc_pred_taken;
    logic [WIDTH-1:0][XLEN-1:0]   alloc_pred_target;
    logic [WIDTH-1:0][XLEN-1:0]   issue_operand;
    logic [WIDTH-1:0]             done_valid;
    logic [WIDTH-1:0][ROBN_W-1:0] done_robn;
    logic [WIDTH-1:0][XLEN-1:0]   done_data;
    logic [WIDTH-1:0]             done_taken;
    logic [WIDTH-1:0][XLEN-1:0]   done_target;
    logic [WIDTH-1:0]             commit_writes;

    dispatch_unit #(.WIDTH(WIDTH), .ROBN_W(ROBN_W)) u_dispatch (
        .clock, .reset,
        .in_valid, .in_op, .in_arn, .in_operand, .in_pred_taken, .in_pred_target,
        .tail_robn, .almost_full, .squash,
        .ready, .alloc_valid, .alloc_robn, .alloc_op, .alloc_arn,
        .alloc_pred_taken, .alloc_pred_target, .issue_operand, .dispatched_count
    );

    rob #(
        .WIDTH(WIDTH), .ROB_SIZE(ROB_SIZE), .ALERT_DEPTH(ALERT_DEPTH), .ROBN_W(ROBN_W)
    ) u_rob (
        .clock, .reset,
        .alloc_valid, .alloc_op, .alloc_arn, .alloc_pred_taken, .alloc_pred_target,
        .done_valid, .done_robn, .done_data, .done_taken, .done_target,
        .tail_robn, .almost_full,
        .commit_valid, .commit_arn, .commit_data, .commit_writes, .squash
    );

    exec_unit #(.WIDTH(WIDTH), .ROB_SIZE(ROB_SIZE), .ROBN_W(ROBN_W)) u_exec (
        .clock, .reset,
        .alloc_valid, .alloc_robn, .alloc_op, .issue_operand, .squash,
        .done_valid, .done_robn, .done_data, .done_taken, .done_target
    );

    retire_unit #(.WIDTH(WIDTH)) u_retire (
        .clock, .reset,
        .commit_valid, .commit_arn, .commit_data, .commit_writes,
        .arch_rd_arn, .arch_rd_data, .retired_count
    );

endmodule

//--- logic/retire_unit.sv
`timescale 1ns/1ps

module retire_unit
    import rob_pkg::*;
#(
    parameter int WIDTH = 2
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [WIDTH-1:0]             commit_valid,
    input  logic [WIDTH-1:0][ARN_W-1:0]  commit_arn,
    input  logic [WIDTH-1:0][XLEN-1:0]   commit_data,
    input  logic [WIDTH-1:0]             commit_writes,
    input  logic [ARN_W-1:0]             arch_rd_arn,
    output logic [XLEN-1:0]              arch_rd_data,
    output logic [STAT_W-1:0]            retired_count
);

    localparam int NUM_ARCH = 1 << ARN_W;

    logic [XLEN-1:0]   arch_regs [NUM_ARCH];
    logic [STAT_W-1:0] n_retire;

    // lanes are in program order, so the last write in the loop wins
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < NUM_ARCH; r++) begin
                arch_regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (commit_valid[i] && commit_writes[i]) begin
                    arch_regs[commit_arn[i]] <= commit_data[i];
                end
            end
        end
    end

    // branches count too
    always_comb begin
        n_retire = '0;
        for (int i = 0; i < WIDTH; i++) begin
            n_retire = n_retire + STAT_W'(commit_valid[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            retired_count <= '0;
        end else begin
            retired_count <= retired_count + n_retire;
        end
    end

    assign arch_rd_data = arch_regs[arch_rd_arn];

endmodule

//--- logic/rob.sv
`timescale 1ns/1ps

module rob
    import rob_pkg::*;
#(
    parameter int WIDTH       = 2,
    parameter int ROB_SIZE    = 16,
    parameter int ALERT_DEPTH = 2,
    parameter int ROBN_W      = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [WIDTH-1:0]              alloc_valid,
    input  op_e  [WIDTH-1:0]              alloc_op,
    input  logic [WIDTH-1:0][ARN_W-1:0]   alloc_arn,
    input  logic [WIDTH-1:0]              alloc_pred_taken,
    input  logic [WIDTH-1:0][XLEN-1:0]    alloc_pred_target,
    input  logic [WIDTH-1:0]              done_valid,
    input  logic [WIDTH-1:0][ROBN_W-1:0]  done_robn,
    input  logic [WIDTH-1:0][XLEN-1:0]    done_data,
    input  logic [WIDTH-1:0]              done_taken,
    input  logic [WIDTH-1:0][XLEN-1:0]    done_target,
    output logic [WIDTH-1:0][ROBN_W-1:0]  tail_robn,
    output logic                          almost_full,
    output logic [WIDTH-1:0]              commit_valid,
    output logic [WIDTH-1:0][ARN_W-1:0]   commit_arn,
    output logic [WIDTH-1:0][XLEN-1:0]    commit_data,
    output logic [WIDTH-1:0]              commit_writes,
    output logic                          squash
);

    localparam int CNT_W = ROBN_W + 1;  // count must reach ROB_SIZE

    typedef struct packed {
        logic             executed;
        logic             success;     // cleared by a failed branch
        op_e              op;
        logic [ARN_W-1:0] arn;
        logic [XLEN-1:0]  data;
        logic             pred_taken;
        logic [XLEN-1:0]  pred_target;
    } rob_entry_t;

    rob_entry_t entries [ROB_SIZE];

    logic [ROBN_W-1:0] head;
    logic [ROBN_W-1:0] tail;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  n_alloc;
    logic [CNT_W-1:0]  n_commit;
    logic [WIDTH-1:0]  alloc_fire;

    assign almost_full = count > CNT_W'(ROB_SIZE - ALERT_DEPTH);

    // lane i lands at tail + i and wraps since ROB_SIZE is a power of two
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            tail_robn[i] = tail + ROBN_W'(i);
        end
    end

    // nothing is allocated in a squash cycle
    assign alloc_fire = alloc_valid & {WIDTH{~squash}};

    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < WIDTH; i++) begin
            n_alloc = n_alloc + CNT_W'(alloc_fire[i]);
        end
    end

    // in-order commit walk from the head
    always_comb begin
        logic              blocked;
        logic [ROBN_W-1:0] ptr;
        blocked       = 1'b0;
        ptr           = head;
        n_commit      = '0;
        squash        = 1'b0;
        commit_valid  = '0;
        commit_arn    = '0;
        commit_data   = '0;
        commit_writes = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (!blocked && count > CNT_W'(i) && entries[ptr].executed) begin
                if (entries[ptr].success) begin
                    commit_valid[i]  = 1'b1;
                    commit_arn[i]    = entries[ptr].arn;
                    commit_data[i]   = entries[ptr].data;
                    commit_writes[i] = entries[ptr].op != op_branch;  // branches write nothing
                    ptr              = ptr + ROBN_W'(1);
                    n_commit         = n_commit + CNT_W'(1);
                end else begin
                    squash  = 1'b1;  // mispredicted branch at head
                    blocked = 1'b1;
                end
            end else begin
                blocked = 1'b1;  // first unfinished entry stops commit
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            head  <= '0;  // flush everything
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ROBN_W'(n_commit);
            tail  <= tail + ROBN_W'(n_alloc);
            count <= count + n_alloc - n_commit;
        end
    end

    // allocation and completion never hit the same slot
    always_ff @(posedge clock) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (alloc_fire[i]) begin
                entries[tail_robn[i]] <= '{
                    executed:    1'b0,
                    success:     1'b1,
                    op:          alloc_op[i],
                    arn:         alloc_arn[i],
                    data:        '0,
                    pred_taken:  alloc_pred_taken[i],
                    pred_target: alloc_pred_target[i]
                };
            end
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (done_valid[i]) begin
                entries[done_robn[i]].executed <= 1'b1;
                entries[done_robn[i]].data     <= done_data[i];
                if (entries[done_robn[i]].op == op_branch) begin
                    // direction and target both have to match
                    entries[done_robn[i]].success <=
                        (done_taken[i] == entries[done_robn[i]].pred_taken) &&
                        (done_target[i] == entries[done_robn[i]].pred_target);
                end
            end
        end
    end

endmodule

//--- logic/rob_pkg.sv
package rob_pkg;

    localparam int XLEN   = 16;  // data and branch target width
    localparam int ARN_W  = 3;   // 8 architectural registers
    localparam int STAT_W = 32;  // dispatched and retired counters

    // execution latencies in cycles
    localparam int LAT_ALU    = 1;
    localparam int LAT_MUL    = 3;
    localparam int LAT_BRANCH = 2;
    localparam int LAT_W      = 2;  // countdown width, holds the longest latency

    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_mul    = 2'd1,
        op_branch = 2'd2
    } op_e;

    // latency loaded into the exec countdown at issue
    function automatic logic [LAT_W-1:0] op_latency(input op_e op);
        logic [LAT_W-1:0] lat;
        case (op)
            op_alu:    lat = LAT_W'(LAT_ALU);
            op_mul:    lat = LAT_W'(LAT_MUL);
            op_branch: lat = LAT_W'(LAT_BRANCH);
            default:   lat = LAT_W'(LAT_ALU);
        endcase
        return lat;
    endfunction

endpackage

//--- run.sh
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module tb_top -Mdir obj_dir \
    && out="$(./obj_dir/Vtb_top)" \
    && echo "$out" \
    && grep -qx "Test OK" <<< "$out" \
    || { echo "simulation did not pass"; exit 1; }

//--- sim.f
+incdir+dv
logic/rob_pkg.sv
logic/dispatch_unit.sv
logic/rob.sv
logic/exec_unit.sv
logic/retire_unit.sv
logic/ooo_core_top.sv
dv/tb_top.sv
